//--- compile.f
+incdir+logic
logic/opm_reg_pkg.sv
logic/opm_bus_capture.sv
logic/opm_slot_store.sv
logic/opm_param_out.sv
logic/opm_reg_top.sv
test/tb_opm_reg_checks.sv
test/tb_opm_reg.sv

//--- logic/opm_bus_capture.sv
`include "opm_reg_cfg.svh"

module opm_bus_capture (
    input  logic                   i_EMUCLK,
    input  logic                   mrst_n,

    // host bus
    input  logic                   i_wr_valid,
    input  opm_reg_pkg::bus_wr_t   i_wr,
    output logic                   o_wr_ready,

    // static registers
    output opm_reg_pkg::lo_regs_t  o_lo,

    // pending high write towards the slot store
    output logic                   o_hi_valid,
    output opm_reg_pkg::hi_wr_t    o_hi_wr,
    input  logic                   i_hi_ready
);
    import opm_reg_pkg::*;

    cap_state_e              state_q;
    logic [`OPM_DATA_W-1:0]  addr_q;        // last address byte
    logic [`OPM_DATA_W-1:0]  hi_data_q;     // data held for the ring
    logic                    wr_fire;
    logic                    addr_wr;
    logic                    data_wr;
    logic                    addr_is_hi;
    hireg_grp_e              hi_grp;
    logic [`OPM_SLOT_W-1:0]  hi_slot;

    //////////////////////////////
    // handshake
    //////////////////////////////

    assign o_wr_ready = (state_q == CAP_IDLE);    // held off while a ring write waits
    assign wr_fire    = i_wr_valid & o_wr_ready;
    assign addr_wr    = wr_fire & (i_wr.acc == ACC_ADDR);
    assign data_wr    = wr_fire & (i_wr.acc == ACC_DATA);

    // 0x20 and up is a ring register
    assign addr_is_hi = |addr_q[7:5];

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            state_q <= CAP_IDLE;
            addr_q  <= '0;
        end else begin
            if (addr_wr) addr_q <= i_wr.data;   // also drops any old high target

            case (state_q)
                CAP_IDLE: begin
                    if (data_wr && addr_is_hi) state_q <= CAP_HI_PEND;
                end
                CAP_HI_PEND: begin
                    if (i_hi_ready) state_q <= CAP_IDLE;    // slot came around
                end
                default: state_q <= CAP_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_EMUCLK) begin
        if (data_wr && addr_is_hi) hi_data_q <= i_wr.data;
    end

    //////////////////////////////
    // high address split
    //////////////////////////////

    always_comb begin
        if (addr_q[7:6] == 2'b00) begin
            // 0x20 to 0x3F, channel in the low 3 bits
            hi_grp  = hireg_grp_e'({2'b00, addr_q[4:3]});
            hi_slot = {2'b00, addr_q[2:0]};
        end else begin
            hi_grp  = hireg_grp_e'({1'b1, addr_q[7:5]});
            hi_slot = addr_q[4:0];
        end
    end

    assign o_hi_valid   = (state_q == CAP_HI_PEND);
    assign o_hi_wr.grp  = hi_grp;
    assign o_hi_wr.slot = hi_slot;
    assign o_hi_wr.data = hi_data_q;

    //////////////////////////////
    // low registers
    //////////////////////////////

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            o_lo <= '0;
        end else if (data_wr && !addr_is_hi) begin
            case (addr_q)
                `OPM_ADDR_TEST: begin
                    o_lo.test <= i_wr.data;
                end
                `OPM_ADDR_NOISE: begin
                    o_lo.ne   <= i_wr.data[7];
                    o_lo.nfrq <= i_wr.data[4:0];
                end
                `OPM_ADDR_LFRQ: begin
                    o_lo.lfrq <= i_wr.data;
                end
                `OPM_ADDR_PMD_AMD: begin
                    if (i_wr.data[7]) begin
                        o_lo.pmd <= i_wr.data[6:0];
                    end else begin
                        o_lo.amd <= i_wr.data[6:0];
                    end
                end
                `OPM_ADDR_WAVE: begin
                    o_lo.ct <= i_wr.data[7:6];
                    o_lo.w  <= i_wr.data[1:0];
                end
                default: begin
                    o_lo <= o_lo;   // unknown low address, data dropped
                end
            endcase
        end
    end

endmodule

//--- logic/opm_param_out.sv
`include "opm_reg_cfg.svh"

module opm_param_out (
    input  logic                           i_EMUCLK,
    input  logic                           mrst_n,

    // ring heads, valid every cycle
    input  opm_reg_pkg::ch_params_t        i_ch_head,
    input  opm_reg_pkg::op_params_t        i_op_head,
    input  logic [`OPM_SLOT_W-1:0]         i_head_slot,

    // per slot stream for the EG and PG
    output logic [`OPM_SLOT_W-1:0]         o_slot,
    output opm_reg_pkg::ch_params_t        o_ch,
    output opm_reg_pkg::op_params_t        o_op
);
    import opm_reg_pkg::*;

    ch_params_t ch_masked;

    //////////////////////////////
    // am enable mask
    //////////////////////////////

    // ams only reaches operators with amen set
    always_comb begin
        ch_masked     = i_ch_head;
        ch_masked.ams = i_ch_head.ams & {2{i_op_head.amen}};
    end

    //////////////////////////////
    // output register
    //////////////////////////////

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            // counter sits at 0 in reset so the tag shows the slot before it
            o_slot <= '1;
            o_ch   <= '0;
            o_op   <= '0;
        end else begin
            o_slot <= i_head_slot;
            o_ch   <= ch_masked;
            o_op   <= i_op_head;
        end
    end

endmodule

//--- logic/opm_reg_cfg.svh
`ifndef OPM_REG_CFG_SVH
`define OPM_REG_CFG_SVH

//////////////////////////////
// bus and slot geometry
//////////////////////////////

// host bus width
`define OPM_DATA_W      8

// operator slots per sample, one per clock
`define OPM_SLOTS       32

// channels, each owns four slots
`define OPM_CHANNELS    8

// slot counter width
`define OPM_SLOT_W      5

//////////////////////////////
// low register addresses
//////////////////////////////

`define OPM_ADDR_TEST       8'h01   // test bits
`define OPM_ADDR_NOISE      8'h0F   // ne and nfrq
`define OPM_ADDR_LFRQ       8'h18   // lfo frequency
`define OPM_ADDR_PMD_AMD    8'h19   // d7 picks pmd or amd
`define OPM_ADDR_WAVE       8'h1B   // ct and waveform

`endif

//--- logic/opm_reg_pkg.sv
`include "opm_reg_cfg.svh"

package opm_reg_pkg;

    //////////////////////////////
    // enums
    //////////////////////////////

    // bus access kind, taken straight from A0
    typedef enum logic {
        ACC_ADDR = 1'b0,
        ACC_DATA = 1'b1
    } bus_acc_e;

    // capture stage state
    typedef enum logic {
        CAP_IDLE    = 1'b0,
        CAP_HI_PEND = 1'b1
    } cap_state_e;

    // high register groups
    // channel groups keep addr[4:3] in the low bits
    // operator groups set bit 3 and keep addr[7:5] below it
    typedef enum logic [3:0] {
        GRP_ALG_RL   = 4'h0,    // 0x20
        GRP_KC       = 4'h1,    // 0x28
        GRP_KF       = 4'h2,    // 0x30
        GRP_PMS_AMS  = 4'h3,    // 0x38
        GRP_DT1_MUL  = 4'hA,    // 0x40
        GRP_TL       = 4'hB,    // 0x60
        GRP_KS_AR    = 4'hC,    // 0x80
        GRP_AMEN_D1R = 4'hD,    // 0xA0
        GRP_DT2_D2R  = 4'hE,    // 0xC0
        GRP_D1L_RR   = 4'hF     // 0xE0
    } hireg_grp_e;

    //////////////////////////////
    // structs
    //////////////////////////////

    // one host access
    typedef struct packed {
        bus_acc_e                acc;
        logic [`OPM_DATA_W-1:0]  data;
    } bus_wr_t;

    // high write waiting for its slot
    typedef struct packed {
        hireg_grp_e              grp;
        logic [`OPM_SLOT_W-1:0]  slot;
        logic [`OPM_DATA_W-1:0]  data;
    } hi_wr_t;

    // static low registers
    typedef struct packed {
        logic [7:0] test;
        logic       ne;
        logic [4:0] nfrq;
        logic [7:0] lfrq;
        logic [6:0] pmd;
        logic [6:0] amd;
        logic [1:0] w;
        logic [1:0] ct;
    } lo_regs_t;

    // per channel parameters
    typedef struct packed {
        logic [1:0] rl;
        logic [2:0] fl;
        logic [2:0] alg;
        logic [6:0] kc;
        logic [5:0] kf;
        logic [2:0] pms;
        logic [1:0] ams;
    } ch_params_t;

    // per operator parameters
    typedef struct packed {
        logic [2:0] dt1;
        logic [3:0] mul;
        logic [6:0] tl;
        logic [1:0] ks;
        logic [4:0] ar;
        logic       amen;
        logic [4:0] d1r;
        logic [1:0] dt2;
        logic [4:0] d2r;
        logic [3:0] d1l;
        logic [3:0] rr;
    } op_params_t;

endpackage

//--- logic/opm_reg_top.sv
`include "opm_reg_cfg.svh"

module opm_reg_top (
    input  logic                           i_EMUCLK,
    input  logic                           mrst_n,

    // host bus
    input  logic                           i_wr_valid,
    input  opm_reg_pkg::bus_wr_t           i_wr,
    output logic                           o_wr_ready,

    // static registers
    output opm_reg_pkg::lo_regs_t          o_lo,

    // slot stream
    output logic [`OPM_SLOT_W-1:0]         o_slot,
    output opm_reg_pkg::ch_params_t        o_ch,
    output opm_reg_pkg::op_params_t        o_op
);
    import opm_reg_pkg::*;

    logic                    hi_valid;
    hi_wr_t                  hi_wr;
    logic                    hi_ready;
    ch_params_t              ch_head;
    op_params_t              op_head;
    logic [`OPM_SLOT_W-1:0]  head_slot;

    opm_bus_capture u_bus_capture (
        .i_EMUCLK   (i_EMUCLK),
        .mrst_n     (mrst_n),
        .i_wr_valid (i_wr_valid),
        .i_wr       (i_wr),
        .o_wr_ready (o_wr_ready),
        .o_lo       (o_lo),
        .o_hi_valid (hi_valid),
        .o_hi_wr    (hi_wr),
        .i_hi_ready (hi_ready)
    );

    opm_slot_store u_slot_store (
        .i_EMUCLK    (i_EMUCLK),
        .mrst_n      (mrst_n),
        .i_hi_valid  (hi_valid),
        .i_hi_wr     (hi_wr),
        .o_hi_ready  (hi_ready),
        .o_ch_head   (ch_head),
        .o_op_head   (op_head),
        .o_head_slot (head_slot)
    );

    opm_param_out u_param_out (
        .i_EMUCLK    (i_EMUCLK),
        .mrst_n      (mrst_n),
        .i_ch_head   (ch_head),
        .i_op_head   (op_head),
        .i_head_slot (head_slot),
        .o_slot      (o_slot),
        .o_ch        (o_ch),
        .o_op        (o_op)
    );

endmodule

//--- logic/opm_slot_store.sv
`include "opm_reg_cfg.svh"

module opm_slot_store (
    input  logic                           i_EMUCLK,
    input  logic                           mrst_n,

    // pending write from the capture stage
    input  logic                           i_hi_valid,
    input  opm_reg_pkg::hi_wr_t            i_hi_wr,
    output logic                           o_hi_ready,

    // ring heads for the current slot
    output opm_reg_pkg::ch_params_t        o_ch_head,
    output opm_reg_pkg::op_params_t        o_op_head,
    output logic [`OPM_SLOT_W-1:0]         o_head_slot
);
    import opm_reg_pkg::*;

    localparam int CH_W = $clog2(`OPM_CHANNELS);

    logic [`OPM_SLOT_W-1:0]  slot_cnt;
    ch_params_t              ch_ring [`OPM_CHANNELS];
    op_params_t              op_ring [`OPM_SLOTS];
    ch_params_t              ch_tail;
    op_params_t              op_tail;
    logic                    is_op_grp;
    logic                    slot_match;
    logic                    accept;

    //////////////////////////////
    // field merge
    //////////////////////////////

    function automatic ch_params_t ch_merge(input ch_params_t cur, input hireg_grp_e grp,
                                            input logic [`OPM_DATA_W-1:0] d);
        ch_params_t nxt;
        nxt = cur;
        case (grp)
            GRP_ALG_RL: begin
                nxt.rl  = d[7:6];
                nxt.fl  = d[5:3];
                nxt.alg = d[2:0];
            end
            GRP_KC: begin
                nxt.kc = d[6:0];
            end
            GRP_KF: begin
                nxt.kf = d[7:2];
            end
            GRP_PMS_AMS: begin
                nxt.pms = d[6:4];
                nxt.ams = d[1:0];
            end
            default: ;  // operator group, channel untouched
        endcase
        return nxt;
    endfunction

    function automatic op_params_t op_merge(input op_params_t cur, input hireg_grp_e grp,
                                            input logic [`OPM_DATA_W-1:0] d);
        op_params_t nxt;
        nxt = cur;
        case (grp)
            GRP_DT1_MUL: begin
                nxt.dt1 = d[6:4];
                nxt.mul = d[3:0];
            end
            GRP_TL: begin
                nxt.tl = d[6:0];
            end
            GRP_KS_AR: begin
                nxt.ks = d[7:6];
                nxt.ar = d[4:0];
            end
            GRP_AMEN_D1R: begin
                nxt.amen = d[7];
                nxt.d1r  = d[4:0];
            end
            GRP_DT2_D2R: begin
                nxt.dt2 = d[7:6];
                nxt.d2r = d[4:0];
            end
            GRP_D1L_RR: begin
                nxt.d1l = d[7:4];
                nxt.rr  = d[3:0];
            end
            default: ;
        endcase
        return nxt;
    endfunction

    //////////////////////////////
    // slot match
    //////////////////////////////

    assign is_op_grp = i_hi_wr.grp[3];     // operator groups sit at 0xA and up

    // channels only look at the low counter bits
    assign slot_match = is_op_grp ? (i_hi_wr.slot == slot_cnt)
                                  : (i_hi_wr.slot[CH_W-1:0] == slot_cnt[CH_W-1:0]);

    assign o_hi_ready = slot_match;
    assign accept     = i_hi_valid & slot_match;

    // head entry goes back in at the tail, merged when accepted
    assign ch_tail = accept ? ch_merge(ch_ring[0], i_hi_wr.grp, i_hi_wr.data) : ch_ring[0];
    assign op_tail = accept ? op_merge(op_ring[0], i_hi_wr.grp, i_hi_wr.data) : op_ring[0];

    //////////////////////////////
    // rings
    //////////////////////////////

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            slot_cnt <= '0;
            for (int i = 0; i < `OPM_CHANNELS; i++) begin
                ch_ring[i] <= '0;
            end
            for (int i = 0; i < `OPM_SLOTS; i++) begin
                op_ring[i] <= '0;
            end
        end else begin
            slot_cnt <= slot_cnt + 1'b1;    // wraps 31 to 0

            for (int i = 0; i < `OPM_CHANNELS - 1; i++) begin
                ch_ring[i] <= ch_ring[i+1];
            end
            ch_ring[`OPM_CHANNELS-1] <= ch_tail;

            for (int i = 0; i < `OPM_SLOTS - 1; i++) begin
                op_ring[i] <= op_ring[i+1];
            end
            op_ring[`OPM_SLOTS-1] <= op_tail;
        end
    end

    assign o_ch_head   = ch_ring[0];   // channel slot_cnt mod 8
    assign o_op_head   = op_ring[0];
    assign o_head_slot = slot_cnt;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_opm_reg -o sim_opm_reg \
    && ./obj_dir/sim_opm_reg | tee /dev/stderr | grep -qF "*** PASSED ***" \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed"; exit 1; }

//--- test/tb_opm_reg.sv
`include "opm_reg_cfg.svh"

module tb_opm_reg;
    timeunit 1ns;
    timeprecision 1ps;

    import opm_reg_pkg::*;

    localparam int TIMEOUT_CYCLES = 6000;   // ~60 accesses at 70 cycles, plus margin

    logic                    clk;
    logic                    mrst_n;
    logic                    wr_valid;
    bus_wr_t                 wr;
    logic                    wr_ready;
    lo_regs_t                lo;
    logic [`OPM_SLOT_W-1:0]  slot;
    ch_params_t              ch;
    op_params_t              op;
    logic                    check_fail;
    integer                  seed;
    int                      cycles = 0;

    opm_reg_top i_opm_reg_top (
        .i_EMUCLK   (clk),
        .mrst_n     (mrst_n),
        .i_wr_valid (wr_valid),
        .i_wr       (wr),
        .o_wr_ready (wr_ready),
        .o_lo       (lo),
        .o_slot     (slot),
        .o_ch       (ch),
        .o_op       (op)
    );

    tb_opm_reg_checks u_checks (
        .i_EMUCLK   (clk),
        .mrst_n     (mrst_n),
        .i_wr_valid (wr_valid),
        .i_wr       (wr),
        .i_wr_ready (wr_ready),
        .i_lo       (lo),
        .i_slot     (slot),
        .i_ch       (ch),
        .i_op       (op),
        .o_fail     (check_fail)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_failed(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge check_fail) stop_failed("a register check failed");

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) stop_failed("timeout: the test did not finish in time");
    end

    //////////////////////////////
    // bus tasks
    //////////////////////////////

    task automatic draw_byte(output logic [7:0] b);
        logic [31:0] r;
        r = $random(seed);
        b = r[7:0];
    endtask

    // called 2 ns after an edge, returns 2 ns after the transfer edge
    task automatic bus_write(input bus_acc_e acc, input logic [7:0] d);
        wr_valid = 1'b1;
        wr.acc   = acc;
        wr.data  = d;
        while (!wr_ready) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #2;
        wr_valid = 1'b0;
    endtask

    task automatic reg_write(input logic [7:0] a, input logic [7:0] d);
        bus_write(ACC_ADDR, a);
        bus_write(ACC_DATA, d);
    endtask

    // ring write done, then one more pass so the new entry is seen
    task automatic wait_for_ring();
        while (!wr_ready) begin
            @(posedge clk);
            #2;
        end
        repeat (`OPM_SLOTS + 3) @(posedge clk);
        #2;
    endtask

    initial begin
        logic [7:0] r;
        logic [7:0] d;
        seed     = 32'h96d4;
        mrst_n   = 1'b0;
        wr_valid = 1'b0;
        wr       = '0;
        repeat (4) @(posedge clk);
        #2;
        mrst_n = 1'b1;
        repeat (2 * `OPM_SLOTS) @(posedge clk);    // counter wraps twice
        #2;

        // low registers
        draw_byte(d);
        reg_write(`OPM_ADDR_TEST, d);
        draw_byte(d);
        reg_write(`OPM_ADDR_NOISE, d);
        draw_byte(d);
        reg_write(`OPM_ADDR_LFRQ, d);
        draw_byte(d);
        reg_write(`OPM_ADDR_PMD_AMD, d | 8'h80);  // pmd
        draw_byte(d);
        reg_write(`OPM_ADDR_PMD_AMD, d & 8'h7F);  // amd
        draw_byte(d);
        reg_write(`OPM_ADDR_WAVE, d);
        draw_byte(d);
        reg_write(8'h05, d);    // not a register

        // one operator write per group, random slot
        for (int n = 0; n < 6; n++) begin
            draw_byte(r);
            draw_byte(d);
            reg_write({3'(n + 2), r[4:0]}, d);
            wait_for_ring();
        end

        // every channel group on one channel, then ams against amen
        draw_byte(r);
        for (int g = 0; g < 4; g++) begin
            draw_byte(d);
            reg_write({3'b001, 2'(g), r[2:0]}, d);
            wait_for_ring();
        end
        draw_byte(d);
        reg_write({3'b001, 2'b11, r[2:0]}, d | 8'h03);
        wait_for_ring();
        draw_byte(d);
        reg_write({3'b101, 2'b01, r[2:0]}, d | 8'h80);   // amen on slot ch+8
        wait_for_ring();

        // access held behind a pending ring write
        draw_byte(r);
        draw_byte(d);
        reg_write({3'b011, r[4:0]}, d);
        draw_byte(d);
        bus_write(ACC_DATA, d);     // same target again, waits for the first
        reg_write(`OPM_ADDR_TEST, 8'h5A);
        wait_for_ring();

        // low address drops the high target
        draw_byte(r);
        bus_write(ACC_ADDR, {3'b100, r[4:0]});
        draw_byte(d);
        reg_write(`OPM_ADDR_LFRQ, d);
        draw_byte(d);
        bus_write(ACC_DATA, d);
        wait_for_ring();

        repeat (4) @(posedge clk);
        #2;
        if (check_fail) begin
            stop_failed("a register check failed");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

//--- test/tb_opm_reg_checks.sv
`include "opm_reg_cfg.svh"

module tb_opm_reg_checks (
    input  logic                           i_EMUCLK,
    input  logic                           mrst_n,
    input  logic                           i_wr_valid,
    input  opm_reg_pkg::bus_wr_t           i_wr,
    input  logic                           i_wr_ready,
    input  opm_reg_pkg::lo_regs_t          i_lo,
    input  logic [`OPM_SLOT_W-1:0]         i_slot,
    input  opm_reg_pkg::ch_params_t        i_ch,
    input  opm_reg_pkg::op_params_t        i_op,
    output logic                           o_fail
);
    timeunit 1ns;
    timeprecision 1ps;

    import opm_reg_pkg::*;

    logic                    fail_q = 1'b0;
    logic [`OPM_SLOT_W-1:0]  cnt;           // expected slot counter
    logic [7:0]              addr;          // last address byte seen
    logic                    pending;
    logic [7:0]              p_addr;
    logic [7:0]              p_data;
    lo_regs_t                lo_sh;
    ch_params_t              ch_sh [`OPM_CHANNELS];
    op_params_t              op_sh [`OPM_SLOTS];
    logic [`OPM_SLOTS-1:0]   op_stale;      // accepted, old copy still to pass by
    logic [`OPM_CHANNELS-1:0] ch_stale;

    assign o_fail = fail_q;

    task automatic flag_error(input string msg);
        $display("** Error [%0t] %s", $time, msg);
        fail_q = 1'b1;
    endtask

    //////////////////////////////
    // register map of the chip
    //////////////////////////////

    task automatic apply_hi(input logic [7:0] a, input logic [7:0] d);
        ch_params_t c;
        op_params_t o;
        c = ch_sh[a[2:0]];
        o = op_sh[a[4:0]];
        if (a[7:6] == 2'b00) begin
            case (a[4:3])
                2'd0: begin
                    c.rl  = d[7:6];
                    c.fl  = d[5:3];
                    c.alg = d[2:0];
                end
                2'd1: c.kc = d[6:0];
                2'd2: c.kf = d[7:2];
                default: begin
                    c.pms = d[6:4];
                    c.ams = d[1:0];
                end
            endcase
            ch_sh[a[2:0]] = c;
            ch_stale[a[2:0]] = 1'b1;
        end else begin
            case (a[7:5])
                3'd2: begin
                    o.dt1 = d[6:4];
                    o.mul = d[3:0];
                end
                3'd3: o.tl = d[6:0];
                3'd4: begin
                    o.ks = d[7:6];
                    o.ar = d[4:0];
                end
                3'd5: begin
                    o.amen = d[7];
                    o.d1r  = d[4:0];
                end
                3'd6: begin
                    o.dt2 = d[7:6];
                    o.d2r = d[4:0];
                end
                default: begin
                    o.d1l = d[7:4];
                    o.rr  = d[3:0];
                end
            endcase
            op_sh[a[4:0]] = o;
            op_stale[a[4:0]] = 1'b1;
        end
    endtask

    //////////////////////////////
    // shadow model and checks
    //////////////////////////////

    always @(posedge i_EMUCLK) begin : model
        ch_params_t              exp_ch;
        logic [2:0]              oc;
        logic                    op_skip;
        logic                    hit;
        logic [`OPM_SLOT_W-1:0]  prev_slot;
        if (!mrst_n) begin
            cnt      = '0;
            addr     = '0;
            pending  = 1'b0;
            p_addr   = '0;
            p_data   = '0;
            lo_sh    = '0;
            op_stale = '0;
            ch_stale = '0;
            for (int i = 0; i < `OPM_CHANNELS; i++) ch_sh[i] = '0;
            for (int i = 0; i < `OPM_SLOTS; i++) op_sh[i] = '0;
        end else begin
            oc        = i_slot[2:0];
            prev_slot = cnt - 5'd1;     // output lags the counter by one
            op_skip   = op_stale[i_slot];

            assert (i_slot == prev_slot)
                else flag_error($sformatf("o_slot is %0d, expected %0d", i_slot, prev_slot));
            assert (i_wr_ready == !pending)
                else flag_error($sformatf("o_wr_ready is %0b with pending %0b",
                                          i_wr_ready, pending));
            assert (i_lo == lo_sh)
                else flag_error($sformatf("o_lo is %h, expected %h", i_lo, lo_sh));

            if (op_skip) begin
                op_stale[i_slot] = 1'b0;
            end else begin
                assert (i_op == op_sh[i_slot])
                    else flag_error($sformatf("o_op at slot %0d is %h, expected %h",
                                              i_slot, i_op, op_sh[i_slot]));
            end

            if (ch_stale[oc]) begin
                ch_stale[oc] = 1'b0;
            end else if (!op_skip) begin
                exp_ch     = ch_sh[oc];
                exp_ch.ams = op_sh[i_slot].amen ? ch_sh[oc].ams : 2'b00;
                assert (i_ch == exp_ch)
                    else flag_error($sformatf("o_ch at slot %0d is %h, expected %h",
                                              i_slot, i_ch, exp_ch));
            end

            // pending write lands when its slot comes around
            if (pending) begin
                if (p_addr[7:6] == 2'b00) hit = (p_addr[2:0] == cnt[2:0]);
                else hit = (p_addr[4:0] == cnt);
                if (hit) begin
                    apply_hi(p_addr, p_data);
                    pending = 1'b0;
                end
            end

            if (i_wr_valid && i_wr_ready) begin
                if (i_wr.acc == ACC_ADDR) begin
                    addr = i_wr.data;
                end else if (addr >= 8'h20) begin
                    pending = 1'b1;
                    p_addr  = addr;
                    p_data  = i_wr.data;
                end else begin
                    case (addr)
                        `OPM_ADDR_TEST: lo_sh.test = i_wr.data;
                        `OPM_ADDR_NOISE: begin
                            lo_sh.ne   = i_wr.data[7];
                            lo_sh.nfrq = i_wr.data[4:0];
                        end
                        `OPM_ADDR_LFRQ: lo_sh.lfrq = i_wr.data;
                        `OPM_ADDR_PMD_AMD: begin
                            if (i_wr.data[7]) lo_sh.pmd = i_wr.data[6:0];
                            else lo_sh.amd = i_wr.data[6:0];
                        end
                        `OPM_ADDR_WAVE: begin
                            lo_sh.ct = i_wr.data[7:6];
                            lo_sh.w  = i_wr.data[1:0];
                        end
                        default: ;  // unknown low address
                    endcase
                end
            end
            cnt = cnt + 5'd1;
        end
    end

endmodule
